// File: Makefile
TOP = tb_udma_rx_channels

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "NO ERRORS" sim.log; then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+common
common/udma_rx_pkg.sv
common/rx_beat_if.sv
rx_channel/udma_rx_addrgen.sv
verilog/udma_rx_arbiter.sv
verilog/udma_rx_capture.sv
verilog/udma_rx_l2_port.sv
verilog/udma_rx_channels.sv
bench/tb_udma_rx_channels.sv

// File: bench/tb_udma_rx_channels.sv
////////////////////
// uDMA RX linear channels testbench
// Table-driven transfers with a memory-side model,
// round-robin order check and write scoreboard
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "udma_rx_config.svh"

module tb_udma_rx_channels import udma_rx_pkg::*;
();

    localparam int N_CH       = `N_LIN_CHANNELS;
    localparam int N_ROWS     = 7;
    localparam int PIPE_SLOTS = `BEAT_FIFO_DEPTH + 1;

    ////////////////////
    // Transfer table
    ////////////////////
    localparam ch_mask_t    ROW_MASK   [N_ROWS] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                    4'b0011, 4'b0101, 4'b1111};
    localparam trans_addr_t ROW_START  [N_ROWS] = '{16'h0000, 16'h0040, 16'h0082, 16'h00C3,
                                                    16'h0200, 16'h0300, 16'h0400};
    localparam trans_addr_t ROW_BYTES  [N_ROWS] = '{16'd16, 16'd8, 16'd8, 16'd5,
                                                    16'd32, 16'd8, 16'd12};
    localparam datasize_t   ROW_SIZE   [N_ROWS] = '{2'd2, 2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd2};
    localparam dest_t       ROW_DEST   [N_ROWS] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2};
    localparam logic        ROW_CONT   [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    localparam int          ROW_EVENTS [N_ROWS] = '{1, 1, 1, 1, 1, 3, 1};

    logic                   clk_i;
    logic                   rstn_i;
    ch_mask_t               lin_ch_valid_i;
    ch_data_t    [N_CH-1:0] lin_ch_data_i;
    datasize_t   [N_CH-1:0] lin_ch_datasize_i;
    dest_t       [N_CH-1:0] lin_ch_destination_i;
    ch_mask_t               lin_ch_ready_o;
    trans_addr_t [N_CH-1:0] cfg_startaddr_i;
    trans_addr_t [N_CH-1:0] cfg_size_i;
    ch_mask_t               cfg_continuous_i;
    ch_mask_t               cfg_en_i;
    ch_mask_t               cfg_clr_i;
    ch_mask_t               lin_ch_en_o;
    trans_addr_t [N_CH-1:0] lin_ch_curr_addr_o;
    trans_addr_t [N_CH-1:0] lin_ch_bytes_left_o;
    ch_mask_t               lin_ch_events_o;
    logic                   l2_req_o;
    logic                   l2_gnt_i;
    l2_addr_t               l2_addr_o;
    l2_be_t                 l2_be_o;
    logic        [31:0]     l2_wdata_o;

    // Reference model state
    int          send_left [N_CH];
    int          ev_seen   [N_CH];
    trans_addr_t mdl_addr  [N_CH];
    trans_addr_t mdl_left  [N_CH];
    trans_addr_t mdl_start [N_CH];
    ch_idx_t     rr_ptr;
    int          inflight;
    int          writes_seen;
    int          cur_row;
    logic [31:0] lcg_state;
    l2_addr_t    exp_addr_q [$];
    l2_be_t      exp_be_q   [$];
    logic [31:0] exp_data_q [$];

    udma_rx_channels i_dut
    (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .lin_ch_valid_i       (lin_ch_valid_i),
        .lin_ch_data_i        (lin_ch_data_i),
        .lin_ch_datasize_i    (lin_ch_datasize_i),
        .lin_ch_destination_i (lin_ch_destination_i),
        .lin_ch_ready_o       (lin_ch_ready_o),
        .cfg_startaddr_i      (cfg_startaddr_i),
        .cfg_size_i           (cfg_size_i),
        .cfg_continuous_i     (cfg_continuous_i),
        .cfg_en_i             (cfg_en_i),
        .cfg_clr_i            (cfg_clr_i),
        .lin_ch_en_o          (lin_ch_en_o),
        .lin_ch_curr_addr_o   (lin_ch_curr_addr_o),
        .lin_ch_bytes_left_o  (lin_ch_bytes_left_o),
        .lin_ch_events_o      (lin_ch_events_o),
        .l2_req_o             (l2_req_o),
        .l2_gnt_i             (l2_gnt_i),
        .l2_addr_o            (l2_addr_o),
        .l2_be_o              (l2_be_o),
        .l2_wdata_o           (l2_wdata_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic trans_addr_t size_bytes(input datasize_t s);
        case (s)
            2'd0:    return 16'd1;
            2'd1:    return 16'd2;
            default: return 16'd4;
        endcase
    endfunction

    function automatic int beats_per_channel(input int r);
        return int'(ROW_BYTES[r] / size_bytes(ROW_SIZE[r])) * ROW_EVENTS[r];
    endfunction

    function automatic int count_total_beats();
        int total;
        total = 0;
        for (int r = 0; r < N_ROWS; r++)
            total += beats_per_channel(r) * $countones(ROW_MASK[r]);
        return total;
    endfunction

    // First requester at or after the priority pointer
    function automatic int rr_winner(input ch_mask_t req);
        int c;
        for (int i = 0; i < N_CH; i++)
        begin
            c = (int'(rr_ptr) + i) % N_CH;
            if (req[c])
                return c;
        end
        return 0;
    endfunction

    function automatic logic beats_pending();
        logic pending;
        pending = (inflight != 0);
        for (int c = 0; c < N_CH; c++)
            if (send_left[c] != 0)
                pending = 1'b1;
        return pending;
    endfunction

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    task automatic record_beat(input int c);
        trans_addr_t a;
        datasize_t   s;
        logic [31:0] data;
        logic [31:0] wdata;
        l2_addr_t    base;
        l2_be_t      be;
        int          nb;
        int          lo;
        a    = mdl_addr[c];
        s    = lin_ch_datasize_i[c];
        data = lin_ch_data_i[c];
        case (lin_ch_destination_i[c])
            2'd1:    base = `APB_BASE;
            2'd2:    base = `CLU_BASE;
            default: base = `L2_BASE;
        endcase
        // Lowest enabled lane is the byte offset aligned down to the access size
        nb    = int'(size_bytes(s));
        lo    = int'(a[1:0]) - (int'(a[1:0]) % nb);
        be    = '0;
        wdata = '0;
        for (int i = 0; i < 4; i++)
        begin
            if (i >= lo && i < lo + nb)
            begin
                be[i]           = 1'b1;
                wdata[8*i +: 8] = data[8*(i-lo) +: 8];
            end
        end
        exp_addr_q.push_back(base | (32'(a) & 32'h0000_FFFC));
        exp_be_q.push_back(be);
        exp_data_q.push_back(wdata);
        mdl_addr[c] = mdl_addr[c] + size_bytes(s);
        mdl_left[c] = mdl_left[c] - size_bytes(s);
        if (mdl_left[c] == '0 && ROW_CONT[cur_row])
        begin
            mdl_addr[c] = mdl_start[c];
            mdl_left[c] = ROW_BYTES[cur_row];
        end
    endtask

    task automatic retire_write();
        if (exp_addr_q.size() == 0)
        begin
            $display("A memory write was granted while no beat was outstanding");
            stop_with_failure();
        end
        else
        begin
            check_value(l2_addr_o, exp_addr_q.pop_front(), "l2_addr_o");
            check_value(32'(l2_be_o), 32'(exp_be_q.pop_front()), "l2_be_o");
            check_value(l2_wdata_o, exp_data_q.pop_front(), "l2_wdata_o");
            inflight--;
            writes_seen++;
        end
    endtask

    // Sample at the falling edge, drive 2 ns after the rising edge
    task automatic run_cycle();
        ch_mask_t    acc;
        int          win;
        logic [31:0] rnd;
        win = 0;
        @(negedge clk_i);
        if (inflight > PIPE_SLOTS)
        begin
            $display("More beats in flight than the capture stage and the FIFO can hold");
            stop_with_failure();
        end
        else if (inflight == PIPE_SLOTS)
            check_value(32'(lin_ch_ready_o), 32'd0, "lin_ch_ready_o with full pipeline");
        if (l2_req_o && l2_gnt_i)
            retire_write();
        acc = lin_ch_ready_o & lin_ch_valid_i;
        if (acc != '0)
        begin
            win = rr_winner(lin_ch_valid_i);
            check_value(32'(acc), 32'd1 << win, "accepted channel mask");
            record_beat(win);
            inflight++;
            rr_ptr = ch_idx_t'(win + 1);
        end
        for (int c = 0; c < N_CH; c++)
            if (lin_ch_events_o[c])
                ev_seen[c]++;
        @(posedge clk_i);
        #2;
        if (acc != '0)
        begin
            send_left[win]--;
            if (send_left[win] == 0)
                lin_ch_valid_i[win] = 1'b0;
            else
                lin_ch_data_i[win] = lcg_next();
        end
        rnd      = lcg_next();
        l2_gnt_i = (rnd[18:16] < 3'd3);
        cfg_en_i  = '0;
        cfg_clr_i = '0;
    endtask

    task automatic verify_row_end(input int r);
        for (int c = 0; c < N_CH; c++)
        begin
            if (ROW_MASK[r][c])
            begin
                check_value(32'(ev_seen[c]), 32'(ROW_EVENTS[r]), "event pulse count");
                check_value(32'(lin_ch_curr_addr_o[c]), 32'(mdl_addr[c]), "lin_ch_curr_addr_o");
                check_value(32'(lin_ch_bytes_left_o[c]), 32'(mdl_left[c]), "lin_ch_bytes_left_o");
                check_value(32'(lin_ch_en_o[c]), 32'(ROW_CONT[r]), "lin_ch_en_o after transfer");
            end
        end
        if (ROW_CONT[r])
        begin
            cfg_clr_i = ROW_MASK[r];
            run_cycle();
            run_cycle();
            check_value(32'(lin_ch_en_o & ROW_MASK[r]), 32'd0, "lin_ch_en_o after clear");
        end
    endtask

    task automatic apply_row(input int r);
        cur_row = r;
        for (int c = 0; c < N_CH; c++)
        begin
            if (ROW_MASK[r][c])
            begin
                mdl_start[c]            = ROW_START[r] + trans_addr_t'(c * 256);
                mdl_addr[c]             = mdl_start[c];
                mdl_left[c]             = ROW_BYTES[r];
                send_left[c]            = beats_per_channel(r);
                ev_seen[c]              = 0;
                cfg_startaddr_i[c]      = mdl_start[c];
                cfg_size_i[c]           = ROW_BYTES[r];
                cfg_continuous_i[c]     = ROW_CONT[r];
                lin_ch_datasize_i[c]    = ROW_SIZE[r];
                lin_ch_destination_i[c] = ROW_DEST[r];
                lin_ch_data_i[c]        = lcg_next();
            end
        end
        cfg_en_i = ROW_MASK[r];
        run_cycle();
        lin_ch_valid_i = ROW_MASK[r];
        while (beats_pending())
            run_cycle();
        run_cycle();
        run_cycle();
        verify_row_end(r);
    endtask

    initial
    begin
        clk_i                = 1'b0;
        rstn_i               = 1'b0;
        lin_ch_valid_i       = '0;
        lin_ch_data_i        = '0;
        lin_ch_datasize_i    = '0;
        lin_ch_destination_i = '0;
        cfg_startaddr_i      = '0;
        cfg_size_i           = '0;
        cfg_continuous_i     = '0;
        cfg_en_i             = '0;
        cfg_clr_i            = '0;
        l2_gnt_i             = 1'b0;
        lcg_state            = 32'd28216;
        rr_ptr               = '0;
        inflight             = 0;
        writes_seen          = 0;
        cur_row              = 0;
        for (int c = 0; c < N_CH; c++)
        begin
            send_left[c] = 0;
            ev_seen[c]   = 0;
        end
        repeat (4) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        check_value(32'(l2_req_o), 32'd0, "l2_req_o after reset");
        check_value(32'(lin_ch_ready_o), 32'd0, "lin_ch_ready_o after reset");
        check_value(32'(lin_ch_en_o), 32'd0, "lin_ch_en_o after reset");
        check_value(32'(lin_ch_events_o), 32'd0, "lin_ch_events_o after reset");
        for (int r = 0; r < N_ROWS; r++)
            apply_row(r);
        if (writes_seen != count_total_beats())
        begin
            $display("Number of memory writes differs from the beats in the table");
            stop_with_failure();
        end
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Watchdog sized from the beats in the table
    initial
    begin
        int limit_cycles;
        limit_cycles = count_total_beats() * 20 + 200;
        repeat (limit_cycles) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: common/rx_beat_if.sv
////////////////////
// Captured RX beat
// Carries one beat from the capture stage to the memory write port
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface rx_beat_if import udma_rx_pkg::*;;

    logic        valid;
    logic        ready;
    trans_addr_t addr;
    datasize_t   size;
    dest_t       dest;
    ch_data_t    data;

    modport capture_mp
    (
        output valid, addr, size, dest, data,
        input  ready
    );

    modport port_mp
    (
        input  valid, addr, size, dest, data,
        output ready
    );

endinterface

`default_nettype wire

// File: common/udma_rx_config.svh
////////////////////
// uDMA RX channel parameters
// Channel count, widths, beat FIFO depth and destination bases
////////////////////
`ifndef UDMA_RX_CONFIG_SVH
`define UDMA_RX_CONFIG_SVH

`define N_LIN_CHANNELS  4
`define TRANS_SIZE      16
`define L2_DATA_WIDTH   32
`define DATA_WIDTH      32
`define DEST_SIZE       2

// Beats buffered between capture and memory
`define BEAT_FIFO_DEPTH 4

// Upper address bytes per destination code
`define L2_BASE         32'h1C00_0000
`define APB_BASE        32'h1A10_0000
`define CLU_BASE        32'h1000_0000

`endif

// File: common/udma_rx_pkg.sv
////////////////////
// uDMA RX shared types
// Address, data, mask and state types of the RX channels
////////////////////
`default_nettype none
`include "udma_rx_config.svh"

package udma_rx_pkg;

    // Channel byte address or byte count
    typedef logic [`TRANS_SIZE-1:0]             trans_addr_t;
    typedef logic [`DATA_WIDTH-1:0]             ch_data_t;
    // 0 byte, 1 halfword, 2 word, 3 illegal
    typedef logic [1:0]                         datasize_t;
    typedef logic [`DEST_SIZE-1:0]              dest_t;
    typedef logic [`N_LIN_CHANNELS-1:0]         ch_mask_t;
    typedef logic [$clog2(`N_LIN_CHANNELS)-1:0] ch_idx_t;

    typedef logic [31:0]                        l2_addr_t;
    typedef logic [`L2_DATA_WIDTH/8-1:0]        l2_be_t;

    typedef enum logic
    {
        ARB_IDLE,
        ARB_HOLD
    } arb_state_t;

endpackage

`default_nettype wire

// File: rx_channel/udma_rx_addrgen.sv
////////////////////
// uDMA RX address generator
// Tracks address and bytes left of one linear channel,
// flags the end of a transfer and reloads in continuous mode
////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_rx_addrgen import udma_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,

    input  trans_addr_t cfg_startaddr_i,
    input  trans_addr_t cfg_size_i,
    input  logic        cfg_continuous_i,
    input  logic        cfg_en_i,
    input  logic        cfg_clr_i,

    input  datasize_t   beat_size_i,
    input  logic        beat_done_i,
    input  logic        grant_i,

    output trans_addr_t curr_addr_o,
    output trans_addr_t bytes_left_o,
    output logic        en_o,
    output logic        event_o
);

    trans_addr_t addr_q;
    trans_addr_t left_q;
    trans_addr_t start_q;
    trans_addr_t len_q;
    logic        cont_q;
    logic        en_q;
    logic        event_q;

    trans_addr_t incr;
    logic        advance;
    logic        last;

    always_comb
    begin
        case (beat_size_i)
            2'd0:    incr = trans_addr_t'(1);
            2'd1:    incr = trans_addr_t'(2);
            default: incr = trans_addr_t'(4);
        endcase
    end

    // Beat of this channel leaves the capture stage
    assign advance = beat_done_i & grant_i;
    assign last    = (left_q <= incr);

    // Reload values for continuous mode
    always_ff @(posedge clk_i)
    begin
        if (cfg_en_i)
        begin
            start_q <= cfg_startaddr_i;
            len_q   <= cfg_size_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            addr_q  <= '0;
            left_q  <= '0;
            cont_q  <= 1'b0;
            en_q    <= 1'b0;
            event_q <= 1'b0;
        end
        else
        begin
            event_q <= 1'b0;
            if (cfg_clr_i)
                en_q <= 1'b0;
            else if (cfg_en_i)
            begin
                en_q   <= 1'b1;
                addr_q <= cfg_startaddr_i;
                left_q <= cfg_size_i;
                cont_q <= cfg_continuous_i;
            end
            else if (advance)
            begin
                if (last)
                begin
                    event_q <= 1'b1;
                    if (cont_q)
                    begin
                        addr_q <= start_q;
                        left_q <= len_q;
                    end
                    else
                    begin
                        en_q   <= 1'b0;
                        addr_q <= addr_q + incr;
                        left_q <= '0;
                    end
                end
                else
                begin
                    addr_q <= addr_q + incr;
                    left_q <= left_q - incr;
                end
            end
        end
    end

    assign curr_addr_o  = addr_q;
    assign bytes_left_o = left_q;
    assign en_o         = en_q;
    assign event_o      = event_q;

    // A captured beat may only retire on an enabled channel
    a_beat_on_enabled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        advance |-> en_q);

endmodule

`default_nettype wire

// File: verilog/udma_rx_arbiter.sv
////////////////////
// uDMA RX arbiter
// Round-robin over the linear channels, grant held until acknowledged
////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_rx_arbiter import udma_rx_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  ch_mask_t req_i,
    input  logic     ack_i,
    output ch_mask_t grant_o,
    output logic     any_grant_o
);

    localparam int N_CH = $bits(ch_mask_t);

    arb_state_t state_q;
    ch_idx_t    prio_q;
    ch_mask_t   hold_q;
    ch_idx_t    hold_idx_q;
    ch_mask_t   hold_live;
    ch_mask_t   rr_grant;
    ch_idx_t    rr_idx;

    // Lowest offset from the priority pointer wins
    always_comb
    begin : rr_search
        ch_idx_t c;
        rr_grant = '0;
        rr_idx   = prio_q;
        for (int i = N_CH - 1; i >= 0; i--)
        begin
            c = ch_idx_t'(prio_q + i);
            if (req_i[c])
            begin
                rr_grant    = '0;
                rr_grant[c] = 1'b1;
                rr_idx      = c;
            end
        end
    end

    // A held grant drops if its channel withdraws
    assign hold_live   = hold_q & req_i;
    assign grant_o     = (state_q == ARB_HOLD) ? hold_live : rr_grant;
    assign any_grant_o = |grant_o;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q    <= ARB_IDLE;
            prio_q     <= '0;
            hold_q     <= '0;
            hold_idx_q <= '0;
        end
        else if (state_q == ARB_IDLE)
        begin
            if (any_grant_o && ack_i)
                prio_q <= rr_idx + 1'b1;
            else if (any_grant_o)
            begin
                state_q    <= ARB_HOLD;
                hold_q     <= rr_grant;
                hold_idx_q <= rr_idx;
            end
        end
        else if (!(|hold_live))
            state_q <= ARB_IDLE;
        else if (ack_i)
        begin
            state_q <= ARB_IDLE;
            prio_q  <= hold_idx_q + 1'b1;
        end
    end

    // An unacknowledged grant stays on its channel while that channel requests
    a_grant_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (any_grant_o && !ack_i) |=>
            ((grant_o == $past(grant_o)) || ((req_i & $past(grant_o)) == '0)));

endmodule

`default_nettype wire

// File: verilog/udma_rx_capture.sv
////////////////////
// uDMA RX input capture
// Muxes the granted channel and registers its beat
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "udma_rx_config.svh"

module udma_rx_capture import udma_rx_pkg::*;
(
    input  logic                                   clk_i,
    input  logic                                   rstn_i,

    input  ch_data_t    [`N_LIN_CHANNELS-1:0]      ch_data_i,
    input  datasize_t   [`N_LIN_CHANNELS-1:0]      ch_size_i,
    input  dest_t       [`N_LIN_CHANNELS-1:0]      ch_dest_i,
    input  ch_mask_t                               grant_i,
    input  logic                                   any_grant_i,
    input  trans_addr_t [`N_LIN_CHANNELS-1:0]      ch_addr_i,

    output ch_mask_t                               ch_ready_o,
    output ch_mask_t                               grant_q_o,
    output datasize_t                              size_q_o,
    rx_beat_if.capture_mp                          beat
);

    ch_data_t    sel_data;
    datasize_t   sel_size;
    dest_t       sel_dest;
    trans_addr_t sel_addr;

    ch_mask_t    grant_q;
    logic        any_q;
    ch_data_t    data_q;
    datasize_t   size_q;
    dest_t       dest_q;

    always_comb
    begin
        sel_data = '0;
        sel_size = '0;
        sel_dest = '0;
        sel_addr = '0;
        for (int i = 0; i < `N_LIN_CHANNELS; i++)
        begin
            if (grant_i[i])
            begin
                sel_data = ch_data_i[i];
                sel_size = ch_size_i[i];
                sel_dest = ch_dest_i[i];
            end
            // Address comes from the generator of the registered beat
            if (grant_q[i])
                sel_addr = ch_addr_i[i];
        end
    end

    assign ch_ready_o = grant_i & {`N_LIN_CHANNELS{beat.ready}};

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            grant_q <= '0;
            any_q   <= 1'b0;
        end
        else if (beat.ready)
        begin
            grant_q <= grant_i;
            any_q   <= any_grant_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (beat.ready)
        begin
            data_q <= sel_data;
            size_q <= sel_size;
            dest_q <= sel_dest;
        end
    end

    assign beat.valid = any_q;
    assign beat.addr  = sel_addr;
    assign beat.size  = size_q;
    assign beat.dest  = dest_q;
    assign beat.data  = data_q;

    assign grant_q_o  = grant_q;
    assign size_q_o   = size_q;

endmodule

`default_nettype wire

// File: verilog/udma_rx_channels.sv
////////////////////
// uDMA RX linear channels
// Four linear channels sharing one 32-bit memory write path
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "udma_rx_config.svh"

module udma_rx_channels import udma_rx_pkg::*;
(
    input  logic                                   clk_i,
    input  logic                                   rstn_i,

    input  ch_mask_t                               lin_ch_valid_i,
    input  ch_data_t    [`N_LIN_CHANNELS-1:0]      lin_ch_data_i,
    input  datasize_t   [`N_LIN_CHANNELS-1:0]      lin_ch_datasize_i,
    input  dest_t       [`N_LIN_CHANNELS-1:0]      lin_ch_destination_i,
    output ch_mask_t                               lin_ch_ready_o,

    input  trans_addr_t [`N_LIN_CHANNELS-1:0]      cfg_startaddr_i,
    input  trans_addr_t [`N_LIN_CHANNELS-1:0]      cfg_size_i,
    input  ch_mask_t                               cfg_continuous_i,
    input  ch_mask_t                               cfg_en_i,
    input  ch_mask_t                               cfg_clr_i,

    output ch_mask_t                               lin_ch_en_o,
    output trans_addr_t [`N_LIN_CHANNELS-1:0]      lin_ch_curr_addr_o,
    output trans_addr_t [`N_LIN_CHANNELS-1:0]      lin_ch_bytes_left_o,
    output ch_mask_t                               lin_ch_events_o,

    output logic                                   l2_req_o,
    input  logic                                   l2_gnt_i,
    output l2_addr_t                               l2_addr_o,
    output l2_be_t                                 l2_be_o,
    output logic        [`L2_DATA_WIDTH-1:0]       l2_wdata_o
);

    ch_mask_t  req;
    ch_mask_t  grant;
    logic      any_grant;
    ch_mask_t  grant_q;
    datasize_t size_q;

    rx_beat_if beat_if ();

    // Only enabled channels compete
    assign req = lin_ch_valid_i & lin_ch_en_o;

    for (genvar g = 0; g < `N_LIN_CHANNELS; g++)
    begin : g_ch
        udma_rx_addrgen i_addrgen
        (
            .clk_i            (clk_i),
            .rstn_i           (rstn_i),
            .cfg_startaddr_i  (cfg_startaddr_i[g]),
            .cfg_size_i       (cfg_size_i[g]),
            .cfg_continuous_i (cfg_continuous_i[g]),
            .cfg_en_i         (cfg_en_i[g]),
            .cfg_clr_i        (cfg_clr_i[g]),
            .beat_size_i      (size_q),
            .beat_done_i      (beat_if.ready),
            .grant_i          (grant_q[g]),
            .curr_addr_o      (lin_ch_curr_addr_o[g]),
            .bytes_left_o     (lin_ch_bytes_left_o[g]),
            .en_o             (lin_ch_en_o[g]),
            .event_o          (lin_ch_events_o[g])
        );
    end

    udma_rx_arbiter i_arbiter
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (req),
        .ack_i       (beat_if.ready),
        .grant_o     (grant),
        .any_grant_o (any_grant)
    );

    udma_rx_capture i_capture
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .ch_data_i   (lin_ch_data_i),
        .ch_size_i   (lin_ch_datasize_i),
        .ch_dest_i   (lin_ch_destination_i),
        .grant_i     (grant),
        .any_grant_i (any_grant),
        .ch_addr_i   (lin_ch_curr_addr_o),
        .ch_ready_o  (lin_ch_ready_o),
        .grant_q_o   (grant_q),
        .size_q_o    (size_q),
        .beat        (beat_if.capture_mp)
    );

    udma_rx_l2_port i_l2_port
    (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .beat       (beat_if.port_mp),
        .l2_req_o   (l2_req_o),
        .l2_gnt_i   (l2_gnt_i),
        .l2_addr_o  (l2_addr_o),
        .l2_be_o    (l2_be_o),
        .l2_wdata_o (l2_wdata_o)
    );

endmodule

`default_nettype wire

// File: verilog/udma_rx_l2_port.sv
////////////////////
// uDMA RX memory write port
// Buffers beats and turns the head beat into a 32-bit write
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "udma_rx_config.svh"

module udma_rx_l2_port import udma_rx_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rstn_i,

    rx_beat_if.port_mp                beat,

    output logic                      l2_req_o,
    input  logic                      l2_gnt_i,
    output l2_addr_t                  l2_addr_o,
    output l2_be_t                    l2_be_o,
    output logic [`L2_DATA_WIDTH-1:0] l2_wdata_o
);

    localparam int DEPTH = `BEAT_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    trans_addr_t   addr_mem [DEPTH];
    datasize_t     size_mem [DEPTH];
    dest_t         dest_mem [DEPTH];
    ch_data_t      data_mem [DEPTH];

    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [PW:0]   count_q;
    logic          push;
    logic          pop;

    trans_addr_t   head_addr;
    datasize_t     head_size;
    dest_t         head_dest;
    ch_data_t      head_data;
    l2_addr_t      base;

    ////////////////////
    // Beat FIFO
    ////////////////////
    assign beat.ready = (count_q != (PW+1)'(DEPTH));
    assign l2_req_o   = (count_q != '0);
    assign push       = beat.valid & beat.ready;
    assign pop        = l2_req_o & l2_gnt_i;

    always_ff @(posedge clk_i)
    begin
        if (push)
        begin
            addr_mem[wr_ptr_q] <= beat.addr;
            size_mem[wr_ptr_q] <= beat.size;
            dest_mem[wr_ptr_q] <= beat.dest;
            data_mem[wr_ptr_q] <= beat.data;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push)
                count_q <= count_q - 1'b1;
        end
    end

    assign head_addr = addr_mem[rd_ptr_q];
    assign head_size = size_mem[rd_ptr_q];
    assign head_dest = dest_mem[rd_ptr_q];
    assign head_data = data_mem[rd_ptr_q];

    ////////////////////
    // Write formatting
    ////////////////////
    always_comb
    begin
        case (head_dest)
            2'd1:    base = `APB_BASE;
            2'd2:    base = `CLU_BASE;
            default: base = `L2_BASE;
        endcase
    end

    assign l2_addr_o = base | l2_addr_t'({head_addr[`TRANS_SIZE-1:2], 2'b00});

    // Lanes follow the low address bits
    always_comb
    begin
        case (head_size)
            2'd0:
            begin
                l2_be_o    = l2_be_t'(1) << head_addr[1:0];
                l2_wdata_o = {24'h0, head_data[7:0]} << {head_addr[1:0], 3'b000};
            end
            2'd1:
            begin
                l2_be_o    = head_addr[1] ? 4'b1100 : 4'b0011;
                l2_wdata_o = head_addr[1] ? {head_data[15:0], 16'h0} : {16'h0, head_data[15:0]};
            end
            2'd2:
            begin
                l2_be_o    = 4'b1111;
                l2_wdata_o = head_data;
            end
            default:
            begin
                l2_be_o    = '0;
                l2_wdata_o = '0;
            end
        endcase
    end

    a_legal_size: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push |-> (beat.size != 2'd3));

endmodule

`default_nettype wire
